// ==== compile.f ====
icache_pkg.sv
icache_tag_array.sv
icache_data_array.sv
icache_lru.sv
icache_verify.sv
icache_top.sv
icache_checker.sv
tb_icache.sv

// ==== tb_icache.sv ====
`timescale 1ns/100ps

module tb_icache
  import icache_pkg::*;
();

  localparam int RESET_CYCLES       = 10;
  localparam int MAX_DELAY          = 4;
  localparam int DIRECTED_FETCHES   = 14;
  localparam int RANDOM_FETCHES     = 300;
  // Gap, pipeline, request hold and fill wait of one fetch
  localparam int WORST_FETCH_CYCLES = 2 * MAX_DELAY + 10;
  localparam int DRAIN_CYCLES       = WORST_FETCH_CYCLES;
  localparam int TIMEOUT_CYCLES     = RESET_CYCLES + DRAIN_CYCLES + 200
                                      + (DIRECTED_FETCHES + RANDOM_FETCHES)
                                      * WORST_FETCH_CYCLES;

  logic   clk_i;
  logic   reset_i;
  logic   fetch_v_i;
  vaddr_t fetch_vaddr_i;
  logic   fetch_ready_o;
  ptag_t  ptag_i;
  logic   ptag_v_i;
  instr_t data_o;
  logic   data_v_o;
  logic   req_v_o;
  paddr_t req_paddr_o;
  logic   req_yumi_i;
  logic   fill_v_i;
  block_t fill_data_i;

  int errors;
  int fetches;
  int hits;
  int misses;
  int dropped;

  integer seed = 32'h4409_0693;

  // Translation side of the fetch now in tag lookup
  logic   ptag_ok;
  logic   lookup_pending = 1'b0;
  logic   lookup_ok      = 1'b0;
  vaddr_t lookup_addr    = '0;

  icache_top dut_i
  (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .fetch_v_i     (fetch_v_i),
    .fetch_vaddr_i (fetch_vaddr_i),
    .fetch_ready_o (fetch_ready_o),
    .ptag_i        (ptag_i),
    .ptag_v_i      (ptag_v_i),
    .data_o        (data_o),
    .data_v_o      (data_v_o),
    .req_v_o       (req_v_o),
    .req_paddr_o   (req_paddr_o),
    .req_yumi_i    (req_yumi_i),
    .fill_v_i      (fill_v_i),
    .fill_data_i   (fill_data_i)
  );

  icache_checker check_i
  (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .fetch_v_i     (fetch_v_i),
    .fetch_vaddr_i (fetch_vaddr_i),
    .fetch_ready_i (fetch_ready_o),
    .ptag_v_i      (ptag_v_i),
    .ptag_i        (ptag_i),
    .data_i        (data_o),
    .data_v_i      (data_v_o),
    .req_v_i       (req_v_o),
    .req_paddr_i   (req_paddr_o),
    .req_yumi_i    (req_yumi_i),
    .fill_v_i      (fill_v_i),
    .fill_data_i   (fill_data_i),
    .errors_o      (errors),
    .fetches_o     (fetches),
    .hits_o        (hits),
    .misses_o      (misses),
    .dropped_o     (dropped)
  );

  //////////////////////////////////////////////////////////////////////
  // Memory contents
  //////////////////////////////////////////////////////////////////////

  // Each word is an odd-constant hash of its own byte address
  function automatic instr_t mem_word(input paddr_t addr);
    logic [31:0] a;
    a = {{(32-PADDR_W){1'b0}}, addr};
    return (a * 32'h9E37_79B1) ^ 32'h3C6E_F372;
  endfunction

  function automatic block_t build_block(input paddr_t addr);
    block_t blk;
    for (int w = 0; w < BLOCK_W / INSTR_W; w++)
    begin
      blk[w*INSTR_W +: INSTR_W] = mem_word({addr[PADDR_W-1:OFFSET_W], w[1:0], 2'b00});
    end
    return blk;
  endfunction

  function automatic vaddr_t make_addr(input ptag_t tag, input index_t set,
                                       input logic [1:0] word);
    return {tag, set, word, 2'b00};
  endfunction

  // Small pool of sets and tags so random fetches collide
  function automatic vaddr_t random_addr();
    ptag_t      tag;
    index_t     set;
    logic [1:0] word;
    tag  = ptag_t'({$random(seed)} % 3 + 1);
    set  = index_t'({$random(seed)} % 4);
    word = 2'({$random(seed)} % 4);
    return make_addr(tag, set, word);
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Drivers
  //////////////////////////////////////////////////////////////////////

  initial
  begin
    clk_i = 1'b0;
    forever
    begin
      #20 clk_i = ~clk_i;
    end
  end

  // Holds the fetch until the cache takes it
  task automatic issue_fetch(input vaddr_t addr, input logic ok);
    fetch_v_i     = 1'b1;
    fetch_vaddr_i = addr;
    ptag_ok       = ok;
    @(posedge clk_i);
    while (!fetch_ready_o)
    begin
      @(posedge clk_i);
    end
    @(negedge clk_i);
    fetch_v_i = 1'b0;
  endtask

  task automatic idle_cycles(input int cycles);
    repeat (cycles) @(negedge clk_i);
  endtask

  always @(posedge clk_i)
  begin
    lookup_pending <= fetch_v_i && fetch_ready_o && !reset_i;
    lookup_addr    <= fetch_vaddr_i;
    lookup_ok      <= ptag_ok;
  end

  // Virtual and physical pages are the same
  always @(negedge clk_i)
  begin
    ptag_v_i = lookup_pending && lookup_ok;
    ptag_i   = lookup_addr[VADDR_W-1 -: PTAG_W];
  end

  // Memory side with random acceptance and fill delays
  task automatic serve_miss();
    paddr_t addr;
    int     delay;
    addr  = req_paddr_o;
    delay = {$random(seed)} % (MAX_DELAY + 1);
    repeat (delay) @(negedge clk_i);
    req_yumi_i = 1'b1;
    @(negedge clk_i);
    req_yumi_i = 1'b0;
    delay = {$random(seed)} % (MAX_DELAY + 1);
    repeat (delay) @(negedge clk_i);
    fill_data_i = build_block(addr);
    fill_v_i    = 1'b1;
    @(negedge clk_i);
    fill_v_i = 1'b0;
  endtask

  initial
  begin
    forever
    begin
      @(negedge clk_i);
      if (!reset_i && req_v_o)
      begin
        serve_miss();
      end
    end
  end

  initial
  begin
    repeat (TIMEOUT_CYCLES) @(posedge clk_i);
    $display("timeout after %0d cycles, the cache stopped making progress",
             TIMEOUT_CYCLES);
    $display("test failed");
    $finish;
  end

  //////////////////////////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////////////////////////

  initial
  begin
    vaddr_t addr;
    logic   ok;
    logic   coverage_ok;
    reset_i       = 1'b1;
    fetch_v_i     = 1'b0;
    fetch_vaddr_i = '0;
    ptag_ok       = 1'b0;
    ptag_i        = '0;
    ptag_v_i      = 1'b0;
    req_yumi_i    = 1'b0;
    fill_v_i      = 1'b0;
    fill_data_i   = '0;
    coverage_ok   = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;

    // Cold miss with a younger fetch right behind it
    issue_fetch(make_addr(12'd1, 6'd5, 2'd2), 1'b1);
    issue_fetch(make_addr(12'd2, 6'd6, 2'd0), 1'b1);
    idle_cycles(2);
    // Back-to-back hits on the filled block
    issue_fetch(make_addr(12'd1, 6'd5, 2'd2), 1'b1);
    issue_fetch(make_addr(12'd1, 6'd5, 2'd3), 1'b1);
    idle_cycles(2);

    // A B A C A B in one set
    issue_fetch(make_addr(12'd1, 6'd9, 2'd0), 1'b1);
    idle_cycles(2);
    issue_fetch(make_addr(12'd2, 6'd9, 2'd1), 1'b1);
    idle_cycles(2);
    issue_fetch(make_addr(12'd1, 6'd9, 2'd2), 1'b1);
    idle_cycles(2);
    issue_fetch(make_addr(12'd3, 6'd9, 2'd3), 1'b1);
    idle_cycles(2);
    issue_fetch(make_addr(12'd1, 6'd9, 2'd1), 1'b1);
    idle_cycles(2);
    issue_fetch(make_addr(12'd2, 6'd9, 2'd0), 1'b1);
    idle_cycles(2);

    // Failed translation on an empty and on a resident block
    issue_fetch(make_addr(12'd1, 6'd12, 2'd0), 1'b0);
    idle_cycles(2);
    issue_fetch(make_addr(12'd1, 6'd12, 2'd0), 1'b1);
    idle_cycles(2);
    issue_fetch(make_addr(12'd1, 6'd5, 2'd1), 1'b0);
    idle_cycles(2);
    issue_fetch(make_addr(12'd1, 6'd5, 2'd1), 1'b1);
    idle_cycles(2);

    for (int n = 0; n < RANDOM_FETCHES; n++)
    begin
      addr = random_addr();
      ok   = ({$random(seed)} % 8) != 0;
      issue_fetch(addr, ok);
      idle_cycles({$random(seed)} % 3);
    end

    // Last fetch reaches verify, then any miss it raised gets its fill
    idle_cycles(2);
    while (!fetch_ready_o)
    begin
      @(negedge clk_i);
    end
    idle_cycles(1);

    if (hits == 0 || misses == 0 || dropped == 0)
    begin
      $display("stimulus never produced all of a hit, a miss and a dropped fetch");
      coverage_ok = 1'b0;
    end
    $display("fetches %0d  hits %0d  misses %0d  dropped %0d  errors %0d",
             fetches, hits, misses, dropped, errors);
    if (errors == 0 && coverage_ok)
    begin
      $display("test passed");
    end
    else
    begin
      $display("test failed");
    end
    $finish;
  end

endmodule

// ==== icache_checker.sv ====
`timescale 1ns/100ps

module icache_checker
  import icache_pkg::*;
(
  input  logic   clk_i,
  input  logic   reset_i,
  input  logic   fetch_v_i,
  input  vaddr_t fetch_vaddr_i,
  input  logic   fetch_ready_i,
  input  logic   ptag_v_i,
  input  ptag_t  ptag_i,
  input  instr_t data_i,
  input  logic   data_v_i,
  input  logic   req_v_i,
  input  paddr_t req_paddr_i,
  input  logic   req_yumi_i,
  input  logic   fill_v_i,
  input  block_t fill_data_i,
  output int     errors_o,
  output int     fetches_o,
  output int     hits_o,
  output int     misses_o,
  output int     dropped_o
);

  // Shadow cache
  ptag_t  tag_m   [SETS][WAYS];
  logic   valid_m [SETS][WAYS];
  way_t   lru_m   [SETS];
  block_t data_m  [SETS][WAYS];

  state_e state_m;
  paddr_t miss_addr_m;
  way_t   miss_way_m;

  // Fetches in tag lookup and tag verify
  logic   tl_v;
  vaddr_t tl_addr;
  logic   tv_v;
  paddr_t tv_addr;

  index_t set;
  ptag_t  tag;
  way_t   way;
  block_t blk;
  logic   tv_hit;
  logic   tv_miss;
  logic   exp_ready;

  function automatic string state_name(input state_e s);
    case (s)
      e_ready: return "ready";
      e_req:   return "request";
      default: return "wait";
    endcase
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected)
    begin
      $display("[FAIL] %0t %s expected %0h got %0h", $time, name, expected, actual);
      errors_o = errors_o + 1;
    end
  endtask

  always @(posedge clk_i)
  begin
    if (reset_i)
    begin
      for (int s = 0; s < SETS; s++)
      begin
        lru_m[s] = 1'b0;
        for (int w = 0; w < WAYS; w++)
        begin
          valid_m[s][w] = 1'b0;
        end
      end
      state_m   = e_ready;
      tl_v      = 1'b0;
      tv_v      = 1'b0;
      errors_o  = 0;
      fetches_o = 0;
      hits_o    = 0;
      misses_o  = 0;
      dropped_o = 0;
    end
    else
    begin
      tv_hit  = 1'b0;
      tv_miss = 1'b0;

      ////////////////////////////////////////////////////////////////////
      // Tag verify
      ////////////////////////////////////////////////////////////////////

      if (tv_v)
      begin
        set = tv_addr[OFFSET_W +: INDEX_W];
        tag = tv_addr[PADDR_W-1 -: PTAG_W];
        for (int w = 0; w < WAYS; w++)
        begin
          if (valid_m[set][w] && tag_m[set][w] == tag)
          begin
            tv_hit = 1'b1;
            way    = w[0];
          end
        end
        if (tv_hit)
        begin
          blk = data_m[set][way];
          check_value("data_v_o", 1, data_v_i);
          check_value("data_o",
                      blk[tv_addr[OFFSET_W-1 -: WORD_SEL_W]*INSTR_W +: INSTR_W], data_i);
          lru_m[set] = ~way;
          hits_o     = hits_o + 1;
        end
        else
        begin
          tv_miss     = 1'b1;
          misses_o    = misses_o + 1;
          miss_addr_m = {tv_addr[PADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
          // Empty way first, then the older one
          if (!valid_m[set][0])
          begin
            miss_way_m = 1'b0;
          end
          else if (!valid_m[set][1])
          begin
            miss_way_m = 1'b1;
          end
          else
          begin
            miss_way_m = lru_m[set];
          end
        end
      end
      if (!tv_hit)
      begin
        check_value("data_v_o", 0, data_v_i);
      end

      // Memory side and fetch back-pressure
      if (tv_miss || state_m == e_req)
      begin
        check_value("req_v_o", 1, req_v_i);
        check_value("req_paddr_o", miss_addr_m, req_paddr_i);
      end
      else
      begin
        check_value("req_v_o", 0, req_v_i);
      end
      exp_ready = (state_m == e_ready) && !tv_miss;
      if (fetch_ready_i !== exp_ready)
      begin
        $display("[FAIL] %0t fetch_ready_o expected %0d got %0d in %s state",
                 $time, exp_ready, fetch_ready_i, state_name(state_m));
        errors_o = errors_o + 1;
      end
      if (fill_v_i && state_m != e_wait)
      begin
        $display("a fill arrived while the cache was not waiting for one");
        errors_o = errors_o + 1;
      end

      // Miss FSM
      case (state_m)
        e_ready:
        begin
          if (tv_miss)
          begin
            state_m = req_yumi_i ? e_wait : e_req;
          end
        end
        e_req:
        begin
          if (req_yumi_i)
          begin
            state_m = e_wait;
          end
        end
        default:
        begin
          if (fill_v_i)
          begin
            set                      = miss_addr_m[OFFSET_W +: INDEX_W];
            tag_m[set][miss_way_m]   = miss_addr_m[PADDR_W-1 -: PTAG_W];
            valid_m[set][miss_way_m] = 1'b1;
            data_m[set][miss_way_m]  = fill_data_i;
            state_m                  = e_ready;
          end
        end
      endcase

      // Tag lookup, squashed by a miss ahead or a failed translation
      if (tl_v && ptag_v_i && !tv_miss)
      begin
        tv_v    = 1'b1;
        tv_addr = {ptag_i, tl_addr[PAGE_OFFSET_W-1:0]};
      end
      else
      begin
        if (tl_v)
        begin
          dropped_o = dropped_o + 1;
        end
        tv_v = 1'b0;
      end

      // Decode
      tl_v = fetch_v_i && exp_ready;
      if (tl_v)
      begin
        tl_addr   = fetch_vaddr_i;
        fetches_o = fetches_o + 1;
      end
    end
  end

endmodule

// ==== icache_top.sv ====
`timescale 1ns/100ps

module icache_top
  import icache_pkg::*;
(
  input  logic   clk_i,
  input  logic   reset_i,
  // Fetch request
  input  logic   fetch_v_i,
  input  vaddr_t fetch_vaddr_i,
  output logic   fetch_ready_o,
  // Translation, one cycle after acceptance
  input  ptag_t  ptag_i,
  input  logic   ptag_v_i,
  // Result
  output instr_t data_o,
  output logic   data_v_o,
  // Memory side
  output logic   req_v_o,
  output paddr_t req_paddr_o,
  input  logic   req_yumi_i,
  input  logic   fill_v_i,
  input  block_t fill_data_i
);

  logic              rd_v;
  index_t            rd_index;
  logic [WAYS-1:0]   hit;
  logic [WAYS-1:0]   valid;
  block_t [WAYS-1:0] blocks;
  index_t            lru_index;
  logic              lru_hit_v;
  way_t              lru_hit_way;
  way_t              lru_way;
  logic              fill_en;
  index_t            fill_index;
  way_t              fill_way;
  ptag_t             fill_ptag;

  icache_tag_array tag_array
  (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .rd_v_i       (rd_v),
    .rd_index_i   (rd_index),
    .ptag_i       (ptag_i),
    .fill_v_i     (fill_en),
    .fill_index_i (fill_index),
    .fill_way_i   (fill_way),
    .fill_ptag_i  (fill_ptag),
    .hit_o        (hit),
    .valid_o      (valid)
  );

  icache_data_array data_array
  (
    .clk_i        (clk_i),
    .rd_v_i       (rd_v),
    .rd_index_i   (rd_index),
    .fill_v_i     (fill_en),
    .fill_index_i (fill_index),
    .fill_way_i   (fill_way),
    .fill_data_i  (fill_data_i),
    .block_o      (blocks)
  );

  icache_lru lru
  (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .index_i   (lru_index),
    .hit_v_i   (lru_hit_v),
    .hit_way_i (lru_hit_way),
    .lru_way_o (lru_way)
  );

  icache_verify verify
  (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .fetch_v_i     (fetch_v_i),
    .fetch_vaddr_i (fetch_vaddr_i),
    .fetch_ready_o (fetch_ready_o),
    .ptag_v_i      (ptag_v_i),
    .ptag_i        (ptag_i),
    .hit_i         (hit),
    .valid_i       (valid),
    .block_i       (blocks),
    .lru_way_i     (lru_way),
    .rd_v_o        (rd_v),
    .rd_index_o    (rd_index),
    .lru_index_o   (lru_index),
    .lru_hit_v_o   (lru_hit_v),
    .lru_hit_way_o (lru_hit_way),
    .fill_v_i      (fill_v_i),
    .fill_en_o     (fill_en),
    .fill_index_o  (fill_index),
    .fill_way_o    (fill_way),
    .fill_ptag_o   (fill_ptag),
    .data_o        (data_o),
    .data_v_o      (data_v_o),
    .req_v_o       (req_v_o),
    .req_paddr_o   (req_paddr_o),
    .req_yumi_i    (req_yumi_i)
  );

endmodule

// ==== icache_verify.sv ====
`timescale 1ns/100ps

module icache_verify
  import icache_pkg::*;
(
  input  logic              clk_i,
  input  logic              reset_i,
  // Decode
  input  logic              fetch_v_i,
  input  vaddr_t            fetch_vaddr_i,
  output logic              fetch_ready_o,
  // Tag lookup
  input  logic              ptag_v_i,
  input  ptag_t             ptag_i,
  input  logic [WAYS-1:0]   hit_i,
  input  logic [WAYS-1:0]   valid_i,
  input  block_t [WAYS-1:0] block_i,
  input  way_t              lru_way_i,
  // Array control
  output logic              rd_v_o,
  output index_t            rd_index_o,
  output index_t            lru_index_o,
  output logic              lru_hit_v_o,
  output way_t              lru_hit_way_o,
  input  logic              fill_v_i,
  output logic              fill_en_o,
  output index_t            fill_index_o,
  output way_t              fill_way_o,
  output ptag_t             fill_ptag_o,
  // Tag verify and miss request
  output instr_t            data_o,
  output logic              data_v_o,
  output logic              req_v_o,
  output paddr_t            req_paddr_o,
  input  logic              req_yumi_i
);

  state_e state_r;
  state_e state_n;

  logic   v_tl_r;
  vaddr_t vaddr_tl_r;
  logic   tv_we;

  logic              v_tv_r;
  logic [WAYS-1:0]   hit_tv_r;
  logic [WAYS-1:0]   valid_tv_r;
  block_t [WAYS-1:0] block_tv_r;
  paddr_t            paddr_tv_r;

  logic                  miss_tv;
  way_t                  hit_way_tv;
  block_t                hit_block;
  logic [WORD_SEL_W-1:0] word_sel;
  way_t                  repl_way;
  paddr_t                miss_paddr;
  paddr_t                miss_paddr_r;
  way_t                  repl_way_r;

  //////////////////////////////////////////////////////////////////////
  // Decode and tag lookup
  //////////////////////////////////////////////////////////////////////

  assign fetch_ready_o = (state_r == e_ready) && !miss_tv;
  assign rd_v_o        = fetch_v_i && fetch_ready_o;
  assign rd_index_o    = fetch_vaddr_i[OFFSET_W +: INDEX_W];

  // Younger fetch dies when the one ahead misses
  assign tv_we = v_tl_r && ptag_v_i && !miss_tv;

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      v_tl_r <= 1'b0;
      v_tv_r <= 1'b0;
    end
    else
    begin
      v_tl_r <= rd_v_o;
      v_tv_r <= tv_we;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (rd_v_o)
    begin
      vaddr_tl_r <= fetch_vaddr_i;
    end
    if (tv_we)
    begin
      hit_tv_r   <= hit_i;
      valid_tv_r <= valid_i;
      block_tv_r <= block_i;
      paddr_tv_r <= {ptag_i, vaddr_tl_r[PAGE_OFFSET_W-1:0]};
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Tag verify
  //////////////////////////////////////////////////////////////////////

  assign miss_tv    = v_tv_r && !(|hit_tv_r);
  assign data_v_o   = v_tv_r && (|hit_tv_r);
  assign hit_way_tv = hit_tv_r[1];
  assign hit_block  = block_tv_r[hit_way_tv];
  assign word_sel   = paddr_tv_r[OFFSET_W-1 -: WORD_SEL_W];
  assign data_o     = hit_block[word_sel*INSTR_W +: INSTR_W];

  assign lru_index_o   = paddr_tv_r[OFFSET_W +: INDEX_W];
  assign lru_hit_v_o   = data_v_o;
  assign lru_hit_way_o = hit_way_tv;

  // Empty way first, LRU way otherwise
  always_comb
  begin
    if (!valid_tv_r[0])
    begin
      repl_way = 1'b0;
    end
    else if (!valid_tv_r[1])
    begin
      repl_way = 1'b1;
    end
    else
    begin
      repl_way = lru_way_i;
    end
  end

  assign miss_paddr = {paddr_tv_r[PADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};

  always_ff @(posedge clk_i)
  begin
    if (miss_tv)
    begin
      miss_paddr_r <= miss_paddr;
      repl_way_r   <= repl_way;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Miss FSM
  //////////////////////////////////////////////////////////////////////

  always_comb
  begin
    state_n = state_r;
    case (state_r)
      e_ready:
      begin
        if (miss_tv)
        begin
          state_n = req_yumi_i ? e_wait : e_req;
        end
      end
      e_req:
      begin
        if (req_yumi_i)
        begin
          state_n = e_wait;
        end
      end
      e_wait:
      begin
        if (fill_v_i)
        begin
          state_n = e_ready;
        end
      end
      default:
      begin
        state_n = e_ready;
      end
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      state_r <= e_ready;
    end
    else
    begin
      state_r <= state_n;
    end
  end

  // First request cycle comes straight from verify
  assign req_v_o     = miss_tv || (state_r == e_req);
  assign req_paddr_o = miss_tv ? miss_paddr : miss_paddr_r;

  assign fill_en_o    = fill_v_i && (state_r == e_wait);
  assign fill_index_o = miss_paddr_r[OFFSET_W +: INDEX_W];
  assign fill_ptag_o  = miss_paddr_r[PADDR_W-1 -: PTAG_W];
  assign fill_way_o   = repl_way_r;

  req_hold_a: assert property (@(posedge clk_i) disable iff (reset_i)
    req_v_o && !req_yumi_i |=> req_v_o && $stable(req_paddr_o));

endmodule

// ==== icache_lru.sv ====
`timescale 1ns/100ps

module icache_lru
  import icache_pkg::*;
(
  input  logic   clk_i,
  input  logic   reset_i,
  input  index_t index_i,
  input  logic   hit_v_i,
  input  way_t   hit_way_i,
  output way_t   lru_way_o
);

  // Per set, the way to evict next
  logic [SETS-1:0] lru_r;

  assign lru_way_o = lru_r[index_i];

  // A hit makes the other way the older one
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      lru_r <= '0;
    end
    else if (hit_v_i)
    begin
      lru_r[index_i] <= ~hit_way_i;
    end
  end

endmodule

// ==== icache_data_array.sv ====
`timescale 1ns/100ps

module icache_data_array
  import icache_pkg::*;
(
  input  logic              clk_i,
  input  logic              rd_v_i,
  input  index_t            rd_index_i,
  input  logic              fill_v_i,
  input  index_t            fill_index_i,
  input  way_t              fill_way_i,
  input  block_t            fill_data_i,
  output block_t [WAYS-1:0] block_o
);

  // One block memory per way
  for (genvar w = 0; w < WAYS; w++)
  begin : g_way
    block_t mem [SETS];
    block_t rd_data_r;
    logic   fill_sel;

    assign fill_sel = fill_v_i && (fill_way_i == way_t'(w));

    always_ff @(posedge clk_i)
    begin
      if (fill_sel)
      begin
        mem[fill_index_i] <= fill_data_i;
      end
    end

    // Output keeps the last read until the next fetch
    always_ff @(posedge clk_i)
    begin
      if (rd_v_i)
      begin
        rd_data_r <= mem[rd_index_i];
      end
    end

    assign block_o[w] = rd_data_r;
  end

  // Fills only come while the fetch side is stalled
  rd_fill_excl_a: assert property (@(posedge clk_i)
    !(rd_v_i && fill_v_i));

endmodule

// ==== icache_tag_array.sv ====
`timescale 1ns/100ps

module icache_tag_array
  import icache_pkg::*;
(
  input  logic            clk_i,
  input  logic            reset_i,
  input  logic            rd_v_i,
  input  index_t          rd_index_i,
  input  ptag_t           ptag_i,
  input  logic            fill_v_i,
  input  index_t          fill_index_i,
  input  way_t            fill_way_i,
  input  ptag_t           fill_ptag_i,
  output logic [WAYS-1:0] hit_o,
  output logic [WAYS-1:0] valid_o
);

  ptag_t           tag_mem [WAYS][SETS];
  logic [SETS-1:0] valid_r [WAYS];
  index_t          lookup_index_r;

  // Index of the fetch now in tag lookup
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      lookup_index_r <= '0;
    end
    else if (rd_v_i)
    begin
      lookup_index_r <= rd_index_i;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Fill write
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i)
  begin
    if (fill_v_i)
    begin
      tag_mem[fill_way_i][fill_index_i] <= fill_ptag_i;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      for (int w = 0; w < WAYS; w++)
      begin
        valid_r[w] <= '0;
      end
    end
    else if (fill_v_i)
    begin
      valid_r[fill_way_i][fill_index_i] <= 1'b1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Tag compare against the translated tag
  //////////////////////////////////////////////////////////////////////

  always_comb
  begin
    for (int w = 0; w < WAYS; w++)
    begin
      valid_o[w] = valid_r[w][lookup_index_r];
      hit_o[w]   = valid_o[w] && (tag_mem[w][lookup_index_r] == ptag_i);
    end
  end

  // Replacement never leaves the same tag in two ways of a set
  hit_onehot_a: assert property (@(posedge clk_i) disable iff (reset_i)
    $onehot0(hit_o));

endmodule

// ==== icache_pkg.sv ====
package icache_pkg;

  //////////////////////////////////////////////////////////////////////
  // Cache geometry
  //////////////////////////////////////////////////////////////////////

  localparam int SETS          = 64;
  localparam int WAYS          = 2;

  // Address slicing
  localparam int INDEX_W       = 6;
  localparam int OFFSET_W      = 4;
  // Index and offset fit in the page, so one way is one page
  localparam int PAGE_OFFSET_W = INDEX_W + OFFSET_W;
  localparam int PTAG_W        = 12;
  localparam int PADDR_W       = 22;
  localparam int VADDR_W       = 22;

  // Payload
  localparam int INSTR_W       = 32;
  localparam int BLOCK_W       = 128;
  localparam int WORD_SEL_W    = 2;

  //////////////////////////////////////////////////////////////////////
  // Types
  //////////////////////////////////////////////////////////////////////

  typedef logic [VADDR_W-1:0] vaddr_t;
  typedef logic [PADDR_W-1:0] paddr_t;
  typedef logic [PTAG_W-1:0]  ptag_t;
  typedef logic [INDEX_W-1:0] index_t;
  typedef logic               way_t;
  typedef logic [INSTR_W-1:0] instr_t;
  typedef logic [BLOCK_W-1:0] block_t;

  // Miss handling FSM
  typedef enum logic [1:0]
  {
    e_ready,
    e_req,
    e_wait
  } state_e;

endpackage
